// ==== logic/zx_mem_pkg.sv ====
//==============================
// Memory package
// Bus, SDRAM request, paging types and memory map
//==============================
package zx_mem_pkg;

	localparam int RAM_ADDR_W = 21;            // Physical byte address width

	// One CPU bus cycle, all levels active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
		logic        m1;
	} zx_bus_t;

	typedef struct packed {
		logic                  toggle;         // Inverted once per request
		logic                  we;
		logic [RAM_ADDR_W-1:0] addr;
		logic [7:0]            din;
	} sdram_req_t;

	typedef enum logic [1:0] {
		MODEL_128K  = 2'd0,
		MODEL_48K   = 2'd1,
		MODEL_PLUS3 = 2'd2
	} model_t;

	typedef struct packed {
		logic [7:0] reg_1ffd;
		logic [7:0] reg_7ffd;
	} page_regs_t;

	//==============================
	// Memory map and port decode
	//==============================
	localparam logic [2:0]  ROM_BANK_PREFIX = 3'b101;
	localparam logic        PORT_ULA_ADDR0  = 1'b0;    // ULA answers on even ports
	localparam logic [15:0] PORT_7FFD_ADDR  = 16'h7FFD;
	localparam logic [15:0] PORT_7FFD_MASK  = 16'h8002;
	localparam logic [15:0] PORT_1FFD_ADDR  = 16'h1FFD;
	localparam logic [15:0] PORT_1FFD_MASK  = 16'hF002;
	localparam int          PAGE_LOCK_BIT   = 5;
	localparam logic [2:0]  SCREEN_BANK     = 3'd5;
	localparam logic [2:0]  FIXED_BANK      = 3'd2;

endpackage

// ==== logic/zx_clock_pkg.sv ====
//==============================
// Clock package
// Turbo divider codes and CPU strobe constants
//==============================
package zx_clock_pkg;

	// Ones in the mask set the divider, 2^ones cycles per CPU clock
	typedef enum logic [4:0] {
		TURBO_3M5 = 5'b11111,
		TURBO_7M  = 5'b01111,
		TURBO_14M = 5'b00111,
		TURBO_28M = 5'b00011,
		TURBO_56M = 5'b00001
	} turbo_t;

	localparam int CE_COUNT_W = 6;
	localparam int SETTLE_W   = 2;             // Wait after a speed switch

	// Both bits clear means the CPU outruns the SDRAM
	localparam logic [4:0] FAST_TURBO_MASK = 5'b11000;

endpackage

// ==== logic/cpu_clock_control.sv ====
//==============================
// CPU clock control
// Turbo strobes, speed switching, pause and RAM wait
//==============================
module cpu_clock_control (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  zx_clock_pkg::turbo_t turbo_sel,
	input  logic                 pause_toggle,
	input  logic                 ram_ready,
	output logic                 ce_cpu_p,
	output logic                 ce_cpu_n
);

	logic [zx_clock_pkg::CE_COUNT_W-1:0] counter;
	logic [zx_clock_pkg::CE_COUNT_W-1:0] turbo_ext;
	logic [zx_clock_pkg::CE_COUNT_W-1:0] masked;
	logic [zx_clock_pkg::SETTLE_W-1:0]   settle;
	zx_clock_pkg::turbo_t                turbo;
	logic                                ce_tp;
	logic                                ce_tn;
	logic                                cpu_en;
	logic                                pause;
	logic                                fast;

	assign turbo_ext = zx_clock_pkg::CE_COUNT_W'(turbo);
	assign masked    = counter & turbo_ext;
	assign fast      = (turbo & zx_clock_pkg::FAST_TURBO_MASK) == '0;

	//==============================
	// Strobe generation
	//==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			counter <= '0;
			ce_tp   <= 1'b0;
			ce_tn   <= 1'b0;
		end else begin
			counter <= counter + 1'b1;
			ce_tp   <= masked == '0;
			// Half a period after the positive strobe
			ce_tn   <= (masked ^ turbo_ext ^ (turbo_ext >> 1)) == '0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			pause <= 1'b0;
		else if (pause_toggle)
			pause <= ~pause;
	end

	//==============================
	// Enable gating
	//==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cpu_en <= 1'b1;
			settle <= '0;
			turbo  <= zx_clock_pkg::TURBO_3M5;
		end else if (ce_tn) begin
			if (settle != '0)
				settle <= settle + 1'b1;       // Runs until it wraps to zero
			if (turbo != turbo_sel) begin
				cpu_en <= 1'b0;
				settle <= zx_clock_pkg::SETTLE_W'(1);
				turbo  <= turbo_sel;
			end else if (!cpu_en && settle == '0 && ram_ready) begin
				cpu_en <= ~pause;
			end else if (fast && !ram_ready) begin
				cpu_en <= 1'b0;                // SDRAM wait at 14M and up
			end else if (cpu_en && pause) begin
				cpu_en <= 1'b0;
			end
		end
	end

	assign ce_cpu_p = cpu_en & ce_tp;
	assign ce_cpu_n = cpu_en & ce_tn;

endmodule

// ==== logic/io_port_decoder.sv ====
//==============================
// I/O port decoder
// Port write detect, paging strobes and ULA output
//==============================
module io_port_decoder (
	input  logic                clk_sys,
	input  logic                reset,
	input  zx_mem_pkg::zx_bus_t bus,
	input  logic                locked,
	input  zx_mem_pkg::model_t  model,
	output logic                page_wr_7ffd,
	output logic                page_wr_1ffd,
	output logic [2:0]          border,
	output logic                ear,
	output logic                mic
);

	logic io_wr;
	logic io_wr_old;
	logic io_wr_rise;
	logic sel_ula;
	logic sel_7ffd;
	logic sel_1ffd;

	assign io_wr      = bus.iorq & bus.wr & ~bus.m1;
	assign io_wr_rise = io_wr & ~io_wr_old;

	assign sel_ula  = bus.addr[0] == zx_mem_pkg::PORT_ULA_ADDR0;
	// +3 also needs A14 for 7FFD, 48K has no paging at all
	assign sel_7ffd = ((bus.addr & zx_mem_pkg::PORT_7FFD_MASK) ==
			(zx_mem_pkg::PORT_7FFD_ADDR & zx_mem_pkg::PORT_7FFD_MASK)) &
			(bus.addr[14] | (model != zx_mem_pkg::MODEL_PLUS3)) &
			(model != zx_mem_pkg::MODEL_48K);
	assign sel_1ffd = ((bus.addr & zx_mem_pkg::PORT_1FFD_MASK) ==
			(zx_mem_pkg::PORT_1FFD_ADDR & zx_mem_pkg::PORT_1FFD_MASK)) &
			(model == zx_mem_pkg::MODEL_PLUS3);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_old    <= 1'b0;
			page_wr_7ffd <= 1'b0;
			page_wr_1ffd <= 1'b0;
			border       <= 3'd0;
			ear          <= 1'b0;
			mic          <= 1'b0;
		end else begin
			io_wr_old    <= io_wr;
			page_wr_7ffd <= io_wr_rise & sel_7ffd & ~locked;     // One cycle only
			page_wr_1ffd <= io_wr_rise & sel_1ffd & ~locked;
			if (io_wr_rise && sel_ula) begin
				border <= bus.dout[2:0];
				ear    <= bus.dout[4];
				mic    <= bus.dout[3];
			end
		end
	end

endmodule

// ==== logic/memory_pager.sv ====
//==============================
// Memory pager
// 7FFD/1FFD registers and CPU to physical address map
//==============================
module memory_pager (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  zx_mem_pkg::zx_bus_t                 bus,
	input  zx_mem_pkg::model_t                  model,
	input  logic                                page_wr_7ffd,
	input  logic                                page_wr_1ffd,
	output logic                                locked,
	output logic [zx_mem_pkg::RAM_ADDR_W-1:0]   ram_addr,
	output logic                                ram_wr_allowed
);

	zx_mem_pkg::model_t     model_q;
	zx_mem_pkg::page_regs_t regs;
	logic                   zx48;
	logic                   plus3;
	logic                   special;
	logic                   rom_area;
	logic                   any_hi;
	logic [3:0]             page_rom;
	logic [2:0]             bank;

	always_ff @(posedge clk_sys) begin
		if (reset)
			model_q <= model;                  // Held for the whole run
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			regs <= '0;
		end else begin
			if (page_wr_7ffd)
				regs.reg_7ffd <= bus.dout;
			if (page_wr_1ffd)
				regs.reg_1ffd <= bus.dout;
		end
	end

	assign zx48     = model_q == zx_mem_pkg::MODEL_48K;
	assign plus3    = model_q == zx_mem_pkg::MODEL_PLUS3;
	assign locked   = regs.reg_7ffd[zx_mem_pkg::PAGE_LOCK_BIT] | zx48;
	assign special  = regs.reg_1ffd[0];
	assign any_hi   = |regs.reg_1ffd[2:1];
	assign rom_area = ~special & (bus.addr[15:14] == 2'b00);

	// +3 has four ROMs, the rest pick 48K or 128K
	assign page_rom = plus3 ? {2'b10, regs.reg_1ffd[2], regs.reg_7ffd[4]}
			: {zx48, 2'b11, zx48 | regs.reg_7ffd[4]};

	//==============================
	// Bank select per 16K window
	//==============================
	always_comb begin
		if (special) begin
			case (bus.addr[15:14])             // All-RAM layouts
				2'b00:   bank = {any_hi, 2'b00};
				2'b01:   bank = {any_hi, &regs.reg_1ffd[2:1], 1'b1};
				2'b10:   bank = {any_hi, 2'b10};
				default: bank = {~regs.reg_1ffd[2] & regs.reg_1ffd[1], 2'b11};
			endcase
		end else begin
			case (bus.addr[15:14])
				2'b01:   bank = zx_mem_pkg::SCREEN_BANK;
				2'b10:   bank = zx_mem_pkg::FIXED_BANK;
				2'b11:   bank = regs.reg_7ffd[2:0];
				default: bank = 3'd0;          // ROM window
			endcase
		end
	end

	assign ram_addr = rom_area ? {zx_mem_pkg::ROM_BANK_PREFIX, page_rom, bus.addr[13:0]}
			: {4'd0, bank, bus.addr[13:0]};

	assign ram_wr_allowed = special | bus.addr[15] | bus.addr[14];

endmodule

// ==== logic/sdram_port.sv ====
//==============================
// SDRAM port
// Toggle requests per memory cycle, read data and ready
//==============================
module sdram_port (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  zx_mem_pkg::zx_bus_t                 bus,
	input  logic [zx_mem_pkg::RAM_ADDR_W-1:0]   ram_addr,
	input  logic                                ram_wr_allowed,
	input  logic                                sdram_ack,
	input  logic [15:0]                         sdram_q,
	output zx_mem_pkg::sdram_req_t              sdram_req,
	output logic [7:0]                          ram_dout,
	output logic                                ram_ready
);

	logic ram_rd;
	logic ram_we;
	logic rd_old;
	logic rd_old2;
	logic we_old;
	logic new_req;

	assign ram_rd = bus.mreq & bus.rd;
	assign ram_we = bus.mreq & bus.wr & ram_wr_allowed;

	// Reads wait one extra cycle for the paging to settle
	assign new_req = (rd_old & ~rd_old2) | (ram_we & ~we_old);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_old           <= 1'b0;
			rd_old2          <= 1'b0;
			we_old           <= 1'b0;
			sdram_req.toggle <= 1'b0;
		end else begin
			rd_old  <= ram_rd;
			rd_old2 <= rd_old;
			we_old  <= ram_we;
			if (new_req)
				sdram_req.toggle <= ~sdram_req.toggle;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (new_req) begin
			sdram_req.we   <= ram_we;
			sdram_req.addr <= ram_addr;
			sdram_req.din  <= bus.dout;
		end
	end

	assign ram_dout  = sdram_req.addr[0] ? sdram_q[15:8] : sdram_q[7:0];
	assign ram_ready = (sdram_ack == sdram_req.toggle) & ~new_req;

endmodule

// ==== logic/zx_memory_core.sv ====
//==============================
// Memory and clocking core
//==============================
module zx_memory_core (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  zx_mem_pkg::zx_bus_t    bus,
	input  zx_mem_pkg::model_t     model,
	input  zx_clock_pkg::turbo_t   turbo_sel,
	input  logic                   pause_toggle,
	input  logic                   sdram_ack,
	input  logic [15:0]            sdram_q,
	output zx_mem_pkg::sdram_req_t sdram_req,
	output logic [7:0]             ram_dout,
	output logic                   ram_ready,
	output logic                   ce_cpu_p,
	output logic                   ce_cpu_n,
	output logic [2:0]             border,
	output logic                   ear,
	output logic                   mic
);

	logic                              page_wr_7ffd;
	logic                              page_wr_1ffd;
	logic                              locked;
	logic [zx_mem_pkg::RAM_ADDR_W-1:0] ram_addr;
	logic                              ram_wr_allowed;

	cpu_clock_control cpu_clock_control_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.turbo_sel    (turbo_sel),
		.pause_toggle (pause_toggle),
		.ram_ready    (ram_ready),
		.ce_cpu_p     (ce_cpu_p),
		.ce_cpu_n     (ce_cpu_n)
	);

	io_port_decoder io_port_decoder_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bus          (bus),
		.locked       (locked),
		.model        (model),
		.page_wr_7ffd (page_wr_7ffd),
		.page_wr_1ffd (page_wr_1ffd),
		.border       (border),
		.ear          (ear),
		.mic          (mic)
	);

	memory_pager memory_pager_inst (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.bus            (bus),
		.model          (model),
		.page_wr_7ffd   (page_wr_7ffd),
		.page_wr_1ffd   (page_wr_1ffd),
		.locked         (locked),
		.ram_addr       (ram_addr),
		.ram_wr_allowed (ram_wr_allowed)
	);

	sdram_port sdram_port_inst (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.bus            (bus),
		.ram_addr       (ram_addr),
		.ram_wr_allowed (ram_wr_allowed),
		.sdram_ack      (sdram_ack),
		.sdram_q        (sdram_q),
		.sdram_req      (sdram_req),
		.ram_dout       (ram_dout),
		.ram_ready      (ram_ready)
	);

endmodule

// ==== testbench/zx_tb_clock.sv ====
//==============================
// Testbench clock and reset
//==============================
module zx_tb_clock (
	input  logic restart,
	output logic clk_sys,
	output logic reset
);

	localparam int PERIOD       = 100;
	localparam int RESET_CYCLES = 4;

	int count;

	initial begin
		clk_sys = 1'b0;
		reset   = 1'b1;                        // Power-on reset
		count   = 0;
	end

	always #(PERIOD / 2) clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		if (restart) begin
			reset <= 1'b1;
			count <= 0;
		end else if (reset) begin
			count <= count + 1;
			if (count == RESET_CYCLES - 1)
				reset <= 1'b0;
		end
	end

endmodule

// ==== testbench/zx_memory_core_properties.sv ====
//==============================
// Memory core assertions
// SDRAM request and ULA reset rules
//==============================
module zx_memory_core_properties (
	input logic                   clk_sys,
	input logic                   reset,
	input zx_mem_pkg::sdram_req_t sdram_req,
	input logic                   sdram_ack,
	input logic                   ram_ready,
	input logic                   ear,
	input logic                   mic
);

	int unsigned assert_errors = 0;

	// Pending request must hold until acked
	req_stable: assert property (@(posedge clk_sys) disable iff (reset)
		!ram_ready && (sdram_ack != sdram_req.toggle) |=> $stable(sdram_req))
	else begin
		$error("SDRAM request changed while pending");
		assert_errors++;
	end

	no_rom_write: assert property (@(posedge clk_sys) disable iff (reset)
		(sdram_req.toggle != $past(sdram_req.toggle)) |->
		!(sdram_req.we && sdram_req.addr[zx_mem_pkg::RAM_ADDR_W-1 -: 3] ==
		zx_mem_pkg::ROM_BANK_PREFIX))
	else begin
		$error("Write request issued to the ROM area");
		assert_errors++;
	end

	ula_reset: assert property (@(posedge clk_sys) reset |=> (!ear && !mic))
	else begin
		$error("ear or mic not cleared by reset");
		assert_errors++;
	end

endmodule

bind zx_memory_core zx_memory_core_properties zx_memory_core_properties_inst (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.sdram_req (sdram_req),
	.sdram_ack (sdram_ack),
	.ram_ready (ram_ready),
	.ear       (ear),
	.mic       (mic)
);

// ==== testbench/zx_memory_core_tb.sv ====
//==============================
// Memory core testbench
// Paging table, SDRAM responder, turbo and ULA tests
//==============================
module zx_memory_core_tb;

	localparam int DRIVE_DLY       = 10;
	localparam int REQ_WAIT        = 4;     // Reads raise the request two edges in
	localparam int READY_WAIT      = 16;
	localparam int SETTLE_CYCLES   = 256;   // Covers old period plus settle wrap
	localparam int WINDOW          = 256;
	localparam int EXTRA_TESTS     = 7;
	localparam int CYCLES_PER_TEST = 250;
	localparam int MEM_SIZE        = 1 << zx_mem_pkg::RAM_ADDR_W;
	localparam logic [15:0] P7 = 16'h7FFD;
	localparam logic [15:0] P1 = 16'h1FFD;
	localparam zx_mem_pkg::model_t M128 = zx_mem_pkg::MODEL_128K;
	localparam zx_mem_pkg::model_t M48  = zx_mem_pkg::MODEL_48K;
	localparam zx_mem_pkg::model_t MP3  = zx_mem_pkg::MODEL_PLUS3;

	typedef struct packed {
		zx_mem_pkg::model_t model;
		logic               rst;               // Reset before the row
		logic [1:0]         n_io;
		logic [1:0][15:0]   io_port;
		logic [1:0][7:0]    io_data;
		logic [15:0]        addr;
		logic               wr;
		logic [7:0]         data;
		logic               chk_data;
		logic               exp_req;
		logic [20:0]        exp_addr;
	} row_t;

	logic                   clk_sys;
	logic                   reset;
	logic                   restart;
	zx_mem_pkg::zx_bus_t    bus;
	zx_mem_pkg::model_t     model;
	zx_clock_pkg::turbo_t   turbo_sel;
	logic                   pause_toggle;
	logic                   sdram_ack;
	logic [15:0]            sdram_q;
	zx_mem_pkg::sdram_req_t sdram_req;
	logic [7:0]             ram_dout;
	logic                   ram_ready;
	logic                   ce_cpu_p;
	logic                   ce_cpu_n;
	logic [2:0]             border;
	logic                   ear;
	logic                   mic;

	row_t        rows[$];
	string       row_names[$];
	logic [20:0] log_addr[$];
	logic        log_we[$];
	logic [7:0]  mem [0:MEM_SIZE-1];
	logic [31:0] lfsr = 32'h9d83b4c5;
	logic        table_ready = 1'b0;
	int          fails = 0;
	int          passed = 0;
	int          failed = 0;
	zx_clock_pkg::turbo_t turbo_codes[$] = '{zx_clock_pkg::TURBO_7M, zx_clock_pkg::TURBO_14M,
			zx_clock_pkg::TURBO_28M, zx_clock_pkg::TURBO_56M, zx_clock_pkg::TURBO_3M5};

	zx_tb_clock zx_tb_clock_inst (.restart(restart), .clk_sys(clk_sys), .reset(reset));

	zx_memory_core zx_memory_core_inst (
		.clk_sys(clk_sys), .reset(reset), .bus(bus), .model(model),
		.turbo_sel(turbo_sel), .pause_toggle(pause_toggle),
		.sdram_ack(sdram_ack), .sdram_q(sdram_q), .sdram_req(sdram_req),
		.ram_dout(ram_dout), .ram_ready(ram_ready), .ce_cpu_p(ce_cpu_p),
		.ce_cpu_n(ce_cpu_n), .border(border), .ear(ear), .mic(mic)
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic fb;
		fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	// 16K banks laid end to end from address zero
	function automatic logic [20:0] bank_addr(input logic [2:0] bank, input logic [15:0] a);
		return 21'(bank) * 21'h4000 + 21'(a[13:0]);
	endfunction

	function automatic logic [20:0] rom_addr(input logic [3:0] page, input logic [15:0] a);
		return {zx_mem_pkg::ROM_BANK_PREFIX, page, a[13:0]};
	endfunction

	task automatic add_row(input string name, input zx_mem_pkg::model_t m, input logic rst,
			input logic [1:0] n_io, input logic [15:0] p0, input logic [7:0] d0,
			input logic [15:0] p1, input logic [7:0] d1, input logic [15:0] addr,
			input logic wr, input logic [7:0] data, input logic chk,
			input logic exp_req, input logic [20:0] exp_addr);
		row_t r;
		r = '{m, rst, n_io, {p1, p0}, {d1, d0}, addr, wr, data, chk, exp_req, exp_addr};
		rows.push_back(r);
		row_names.push_back(name);
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual, input int tol);
		logic [31:0] diff;
		diff = (actual > expected) ? actual - expected : expected - actual;
		if ($isunknown(actual) || diff > tol) begin
			$display("** Error: %s expected %0h actual %0h", what, expected, actual);
			fails++;
		end
	endtask

	task automatic report_failure(input string what, input string msg);
		$display("%s: %s", what, msg);
		fails++;
	endtask

	task automatic finish_test(input string name);
		if (fails == 0) begin
			$display("PASS %s", name);
			passed++;
		end else begin
			$display("FAIL %s", name);
			failed++;
		end
		fails = 0;
	endtask

	task automatic reset_dut(input zx_mem_pkg::model_t m);
		@(posedge clk_sys) #DRIVE_DLY;
		model   = m;                           // Latched while reset is high
		restart = 1'b1;
		@(posedge clk_sys) #DRIVE_DLY;
		restart = 1'b0;
		@(negedge clk_sys);
		while (reset)
			@(negedge clk_sys);
	endtask

	task automatic port_write(input logic [15:0] port, input logic [7:0] data);
		@(posedge clk_sys) #DRIVE_DLY;
		bus.addr = port;
		bus.dout = data;
		bus.iorq = 1'b1;
		bus.wr   = 1'b1;
		repeat (2) @(posedge clk_sys);         // Strobe, then page register load
		#DRIVE_DLY;
		bus.iorq = 1'b0;
		bus.wr   = 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic mem_access(input row_t r, input string name);
		logic t0;
		int   n0;
		int   cyc;
		t0 = sdram_req.toggle;
		n0 = log_addr.size();
		@(posedge clk_sys) #DRIVE_DLY;
		bus.addr = r.addr;
		bus.dout = r.data;
		bus.mreq = 1'b1;
		bus.rd   = ~r.wr;
		bus.wr   = r.wr;
		cyc = 0;
		while (sdram_req.toggle == t0 && cyc < REQ_WAIT) begin
			@(negedge clk_sys);
			cyc++;
		end
		if (!r.exp_req) begin
			if (sdram_req.toggle != t0)
				report_failure(name, "an SDRAM request was issued where none was expected");
		end else if (sdram_req.toggle == t0) begin
			report_failure(name, "no SDRAM request was issued");
		end else begin
			cyc = 0;
			while (!ram_ready && cyc < READY_WAIT) begin
				@(negedge clk_sys);
				cyc++;
			end
			if (!ram_ready)
				report_failure(name, "ram_ready did not rise after the request");
			else if (log_addr.size() != n0 + 1)
				report_failure(name, "expected exactly one SDRAM request");
			else begin
				check_value({name, " addr"}, r.exp_addr, log_addr[n0], 0);
				check_value({name, " we"}, r.wr, log_we[n0], 0);
				if (r.chk_data)
					check_value({name, " ram_dout"}, r.data, ram_dout, 0);
			end
		end
		@(posedge clk_sys) #DRIVE_DLY;
		bus.mreq = 1'b0;
		bus.rd   = 1'b0;
		bus.wr   = 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic run_row(input row_t r, input string name);
		if (r.rst)
			reset_dut(r.model);
		for (int i = 0; i < r.n_io; i++)
			port_write(r.io_port[i], r.io_data[i]);
		mem_access(r, name);
		finish_test(name);
	endtask

	// Negative strobe must trail the positive one by half a CPU period
	task automatic count_cpu_pulses(input int half, output int n_p, output int n_n,
			output int late);
		int last_p;
		n_p    = 0;
		n_n    = 0;
		late   = 0;
		last_p = -1;
		for (int i = 0; i < WINDOW; i++) begin
			@(negedge clk_sys);
			if (ce_cpu_p) begin
				n_p++;
				last_p = i;
			end
			if (ce_cpu_n) begin
				n_n++;
				if (last_p >= 0 && i - last_p != half)
					late++;
			end
		end
	endtask

	task automatic ula_port_test();
		port_write(16'h00FE, 8'h1D);           // Border 5, ear and mic set
		@(negedge clk_sys);
		check_value("ula_port border", 3'd5, border, 0);
		check_value("ula_port ear", 1'b1, ear, 0);
		check_value("ula_port mic", 1'b1, mic, 0);
		reset_dut(M128);
		check_value("ula_port border after reset", 3'd0, border, 0);
		check_value("ula_port ear after reset", 1'b0, ear, 0);
		check_value("ula_port mic after reset", 1'b0, mic, 0);
		finish_test("ula_port");
	endtask

	task automatic turbo_rate_test(input zx_clock_pkg::turbo_t code);
		string name;
		int    exp_n;
		int    half;
		int    n_p;
		int    n_n;
		int    late;
		name  = $sformatf("turbo_%05b", code);
		exp_n = WINDOW >> $countones(code);
		half  = (1 << $countones(code)) / 2;
		@(posedge clk_sys) #DRIVE_DLY;
		turbo_sel = code;
		repeat (SETTLE_CYCLES) @(posedge clk_sys);
		count_cpu_pulses(half, n_p, n_n, late);
		check_value({name, " ce_cpu_p count"}, exp_n, n_p, 1);
		check_value({name, " ce_cpu_n count"}, exp_n, n_n, 1);
		check_value({name, " ce_cpu_n phase errors"}, 0, late, 0);
		finish_test(name);
	endtask

	task automatic toggle_pause();
		@(posedge clk_sys) #DRIVE_DLY;
		pause_toggle = 1'b1;
		@(posedge clk_sys) #DRIVE_DLY;
		pause_toggle = 1'b0;
		repeat (SETTLE_CYCLES) @(posedge clk_sys);
	endtask

	task automatic pause_resume_test();
		int exp_n;
		int half;
		int n_p;
		int n_n;
		int late;
		exp_n = WINDOW >> $countones(turbo_sel);
		half  = (1 << $countones(turbo_sel)) / 2;
		toggle_pause();
		count_cpu_pulses(half, n_p, n_n, late);
		check_value("pause ce_cpu_p count while paused", 0, n_p, 0);
		check_value("pause ce_cpu_n count while paused", 0, n_n, 0);
		toggle_pause();
		count_cpu_pulses(half, n_p, n_n, late);
		check_value("pause ce_cpu_p count after resume", exp_n, n_p, 1);
		check_value("pause ce_cpu_n count after resume", exp_n, n_n, 1);
		check_value("pause ce_cpu_n phase errors", 0, late, 0);
		finish_test("pause");
	endtask

	//==============================
	// SDRAM responder
	//==============================
	initial begin
		int          delay;
		logic [20:0] req_addr;
		sdram_ack = 1'b0;
		sdram_q   = '0;
		for (int a = 0; a < MEM_SIZE; a++)
			mem[a] = a[7:0] ^ a[15:8] ^ {3'b000, a[20:16]};
		forever begin
			@(posedge clk_sys) #DRIVE_DLY;
			if (reset) begin
				sdram_ack = 1'b0;
			end else if (sdram_req.toggle != sdram_ack) begin
				req_addr = sdram_req.addr;
				log_addr.push_back(req_addr);
				log_we.push_back(sdram_req.we);
				if (sdram_req.we)
					mem[req_addr] = sdram_req.din;
				delay = 1 + {lfsr_bit(), lfsr_bit()};   // 1 to 4 cycles
				repeat (delay) @(posedge clk_sys);
				#DRIVE_DLY;
				sdram_q   = {mem[{req_addr[20:1], 1'b1}], mem[{req_addr[20:1], 1'b0}]};
				sdram_ack = sdram_req.toggle;
			end
		end
	end

	initial begin
		int limit;
		wait (table_ready);
		limit = (rows.size() + EXTRA_TESTS) * CYCLES_PER_TEST;
		repeat (limit) @(posedge clk_sys);
		$display("Watchdog: run did not finish within %0d clock cycles", limit);
		$display("SOME TESTS FAILED");
		$finish;
	end

	//==============================
	// Main sequence
	//==============================
	initial begin
		int assert_errors;
		bus          = '0;
		model        = M128;
		turbo_sel    = zx_clock_pkg::TURBO_3M5;
		pause_toggle = 1'b0;
		restart      = 1'b0;

		add_row("bank3_c000", M128, 1, 1, P7, 8'h03, 0, 0, 16'hC123, 0, 8'h00, 0, 1,
				bank_addr(3'd3, 16'hC123));
		add_row("rom1_bit4", M128, 0, 1, P7, 8'h10, 0, 0, 16'h0456, 0, 8'h00, 0, 1,
				rom_addr(4'b0111, 16'h0456));
		add_row("rom0_bank7", M128, 0, 1, P7, 8'h07, 0, 0, 16'h0010, 0, 8'h00, 0, 1,
				rom_addr(4'b0110, 16'h0010));
		add_row("bank5_4000", M128, 0, 0, 0, 0, 0, 0, 16'h5ABC, 0, 8'h00, 0, 1,
				bank_addr(3'd5, 16'h5ABC));
		add_row("lock_7ffd", M128, 1, 2, P7, 8'h23, P7, 8'h06, 16'hC010, 0, 8'h00, 0, 1,
				bank_addr(3'd3, 16'hC010));
		add_row("zx48_no_page", M48, 1, 1, P7, 8'h07, 0, 0, 16'hC000, 0, 8'h00, 0, 1,
				bank_addr(3'd0, 16'hC000));
		add_row("zx48_rom", M48, 0, 0, 0, 0, 0, 0, 16'h0200, 0, 8'h00, 0, 1,
				rom_addr(4'b1111, 16'h0200));
		add_row("p3_rom3", MP3, 1, 2, P1, 8'h04, P7, 8'h10, 16'h0100, 0, 8'h00, 0, 1,
				rom_addr(4'b1011, 16'h0100));
		add_row("p3_7ffd_no_a14", MP3, 1, 1, 16'h3FFD, 8'h05, 0, 0, 16'hC000, 0, 8'h00,
				0, 1, bank_addr(3'd0, 16'hC000));
		add_row("p3_special0_wr", MP3, 1, 1, P1, 8'h01, 0, 0, 16'h0122, 1, 8'hA5, 0, 1,
				bank_addr(3'd0, 16'h0122));
		add_row("p3_special0_rd", MP3, 0, 0, 0, 0, 0, 0, 16'h0122, 0, 8'hA5, 1, 1,
				bank_addr(3'd0, 16'h0122));
		add_row("p3_special1", MP3, 0, 1, P1, 8'h03, 0, 0, 16'h0000, 0, 8'h00, 0, 1,
				bank_addr(3'd4, 16'h0000));
		add_row("p3_special2", MP3, 0, 1, P1, 8'h05, 0, 0, 16'hC000, 0, 8'h00, 0, 1,
				bank_addr(3'd3, 16'hC000));
		add_row("p3_special3", MP3, 0, 1, P1, 8'h07, 0, 0, 16'h4000, 0, 8'h00, 0, 1,
				bank_addr(3'd7, 16'h4000));
		add_row("rom_wr_blocked", M128, 1, 0, 0, 0, 0, 0, 16'h1234, 1, 8'h5A, 0, 0, 0);
		add_row("ram_wr_odd", M128, 0, 0, 0, 0, 0, 0, 16'h8011, 1, 8'hC3, 0, 1,
				bank_addr(3'd2, 16'h8011));
		add_row("ram_rd_odd", M128, 0, 0, 0, 0, 0, 0, 16'h8011, 0, 8'hC3, 1, 1,
				bank_addr(3'd2, 16'h8011));
		table_ready = 1'b1;

		@(negedge clk_sys);
		while (reset)
			@(negedge clk_sys);
		foreach (rows[i])
			run_row(rows[i], row_names[i]);
		ula_port_test();
		foreach (turbo_codes[i])
			turbo_rate_test(turbo_codes[i]);
		pause_resume_test();

		assert_errors = zx_memory_core_inst.zx_memory_core_properties_inst.assert_errors;
		$display("Summary: %0d ok, %0d failed, %0d assertion errors",
				passed, failed, assert_errors);
		if (failed == 0 && assert_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== files.f ====
logic/zx_mem_pkg.sv
logic/zx_clock_pkg.sv
logic/cpu_clock_control.sv
logic/io_port_decoder.sv
logic/memory_pager.sv
logic/sdram_port.sv
logic/zx_memory_core.sv
testbench/zx_tb_clock.sv
testbench/zx_memory_core_properties.sv
testbench/zx_memory_core_tb.sv

// ==== Bender.yml ====
package:
  name: zx_memory_core

sources:
  - files:
      - logic/zx_mem_pkg.sv
      - logic/zx_clock_pkg.sv
      - logic/cpu_clock_control.sv
      - logic/io_port_decoder.sv
      - logic/memory_pager.sv
      - logic/sdram_port.sv
      - logic/zx_memory_core.sv
  - target: simulation
    files:
      - testbench/zx_tb_clock.sv
      - testbench/zx_memory_core_properties.sv
      - testbench/zx_memory_core_tb.sv
